/* src.f */
+incdir+verification
hdl/mcu_bus_pkg.sv
hdl/ahb_addr_decoder.sv
hdl/ahb_response_mux.sv
hdl/ahb_ram_slave.sv
hdl/ahb_gpio_slave.sv
hdl/ahb_default_slave.sv
hdl/ahb_matrix.sv
verification/tb_ahb_matrix.sv

/* Makefile */
# Verilator build and run of the AHB-Lite bus matrix testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 -f src.f --top-module tb_ahb_matrix -Mdir $(OBJ_DIR)

# a $fatal in the testbench makes the binary exit non-zero
run: compile
	./$(OBJ_DIR)/Vtb_ahb_matrix

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_ahb_model.svh */
`ifndef TB_AHB_MODEL_SVH
`define TB_AHB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// reference memory map, one entry per byte
logic [7:0]                     boot_bytes [4096];    // 1K words
logic [7:0]                     main_bytes [16384];   // 4K words
logic [mcu_bus_pkg::n_leds-1:0] model_leds;

// a transfer covers 2**size bytes from its address aligned down to that size
function automatic void model_write(input mcu_bus_pkg::ahb_req_t t);
    int nb;
    int base;
    nb   = 1 << t.size;
    base = int'(t.addr.map.offset) & ~(nb - 1);
    if (t.addr.map.seg == mcu_bus_pkg::seg_gpio) begin
        if (t.addr.map.offset[3:2] == 2'd0) begin
            model_leds = t.wdata[mcu_bus_pkg::n_leds-1:0];   // 0x4 and 0x8 are read-only
        end
    end else begin
        for (int b = base; b < base + nb; b++) begin
            if (t.addr.map.seg == mcu_bus_pkg::seg_boot_ram) boot_bytes[b] = t.wdata[8*(b%4) +: 8];
            if (t.addr.map.seg == mcu_bus_pkg::seg_main_ram) main_bytes[b] = t.wdata[8*(b%4) +: 8];
        end
    end
endfunction

function automatic logic [31:0] ram_word(input mcu_bus_pkg::ahb_addr_u a);
    logic [31:0] w;
    int          base;
    base = int'(a.map.offset) & ~3;
    for (int i = 0; i < 4; i++) begin
        if (a.map.seg == mcu_bus_pkg::seg_main_ram) w[8*i +: 8] = main_bytes[base + i];
        else w[8*i +: 8] = boot_bytes[base + i];
    end
    return w;
endfunction

// expected response in a data phase that has already seen stalls wait cycles
function automatic mcu_bus_pkg::ahb_rsp_t expect_rsp(input mcu_bus_pkg::ahb_req_t t,
        input int stalls, input logic [15:0] sw, input logic [3:0] btn);
    mcu_bus_pkg::ahb_rsp_t e;
    int                    waits;
    e       = '0;
    e.resp  = mcu_bus_pkg::resp_okay;
    waits   = 0;
    case (t.addr.map.seg)
        mcu_bus_pkg::seg_boot_ram: e.rdata = ram_word(t.addr);
        mcu_bus_pkg::seg_main_ram: begin
            e.rdata = ram_word(t.addr);
            waits   = t.write ? 0 : 1;   // one wait state on reads only
        end
        mcu_bus_pkg::seg_gpio: begin
            case (t.addr.map.offset[3:2])
                2'd0:    e.rdata[mcu_bus_pkg::n_leds-1:0] = model_leds;
                2'd1:    e.rdata[mcu_bus_pkg::n_switches-1:0] = sw;
                2'd2:    e.rdata[mcu_bus_pkg::n_buttons-1:0] = btn;
                default: e.rdata = '0;
            endcase
        end
        default: begin
            e.resp = mcu_bus_pkg::resp_error;   // two-cycle error
            waits  = 1;
        end
    endcase
    e.ready = (stalls >= waits);
    return e;
endfunction

`endif

/* verification/tb_ahb_matrix.sv */
`timescale 1ns/100ps

module tb_ahb_matrix;

    localparam int         n_xfer_max     = 256;   // queued transfers including idle slots
    localparam int         timeout_cycles = 2 * n_xfer_max * 3;
    localparam logic [2:0] size_word      = 3'b010;

    logic                               HCLK;
    logic                               arst_n;
    mcu_bus_pkg::ahb_req_t              req;
    mcu_bus_pkg::ahb_rsp_t              rsp;
    logic [mcu_bus_pkg::n_switches-1:0] switches;
    logic [mcu_bus_pkg::n_buttons-1:0]  buttons;
    logic [mcu_bus_pkg::n_leds-1:0]     leds;

    integer                seed      = 32'h3c79;
    int                    cycle_cnt = 0;
    int                    n_checks  = 0;
    mcu_bus_pkg::ahb_req_t xfer_q [$];
    logic [31:0]           known_words [$];   // RAM words written in full

    `include "tb_ahb_model.svh"

    ahb_matrix i_ahb_matrix (
        .HCLK     (HCLK),
        .arst_n   (arst_n),
        .req      (req),
        .rsp      (rsp),
        .switches (switches),
        .buttons  (buttons),
        .leds     (leds)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            $display("Some tests failed");
            $fatal(1, "bus hung, run still going after %0d cycles", cycle_cnt);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    task automatic check_rsp(input mcu_bus_pkg::ahb_rsp_t got, input mcu_bus_pkg::ahb_rsp_t want,
                             input logic cmp_data, input string what);
        n_checks++;
        if (got.ready !== want.ready || got.resp !== want.resp
            || (cmp_data && got.rdata !== want.rdata)) begin
            $display("Mismatch at %0t: %s got %b/%b/%h expected %b/%b/%h (ready/resp/rdata)",
                     $time, what, got.ready, got.resp, got.rdata,
                     want.ready, want.resp, want.rdata);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_leds(input logic [mcu_bus_pkg::n_leds-1:0] got,
                              input logic [mcu_bus_pkg::n_leds-1:0] want);
        n_checks++;
        if (got !== want) begin
            $display("Mismatch at %0t: leds %h expected %h", $time, got, want);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [31:0] ram_word_addr(input logic main, input logic [31:0] r);
        mcu_bus_pkg::ahb_addr_u a;
        a.map.seg    = main ? mcu_bus_pkg::seg_main_ram : mcu_bus_pkg::seg_boot_ram;
        a.map.offset = main ? {8'd0, r[13:2], 2'b00} : {10'd0, r[11:2], 2'b00};
        return a.raw;
    endfunction

    function automatic logic [31:0] gpio_addr(input logic [1:0] idx);
        return {mcu_bus_pkg::seg_gpio, 18'd0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] v;
        v = rnd();
        while (v[31:22] == mcu_bus_pkg::seg_main_ram || v[31:22] == mcu_bus_pkg::seg_boot_ram
               || v[31:22] == mcu_bus_pkg::seg_gpio) begin
            v = rnd();
        end
        return {v[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] pick_known();
        return known_words[rnd() % known_words.size()];
    endfunction

    function automatic void queue_xfer(input logic [31:0] addr, input logic write,
                                       input logic [2:0] size, input logic [31:0] wdata);
        mcu_bus_pkg::ahb_req_t t;
        t.addr.raw = addr;
        t.trans    = mcu_bus_pkg::trans_nonseq;
        t.write    = write;
        t.size     = size;
        t.wdata    = wdata;
        xfer_q.push_back(t);
    endfunction

    function automatic void add_idle_cycles(input int n);
        mcu_bus_pkg::ahb_req_t t;
        t       = '0;
        t.trans = mcu_bus_pkg::trans_idle;
        repeat (n) xfer_q.push_back(t);
    endfunction

    // AHB master with the address phase of one transfer overlapping the data phase before it
    task automatic run_queue();
        mcu_bus_pkg::ahb_req_t ap;
        mcu_bus_pkg::ahb_req_t dp;
        mcu_bus_pkg::ahb_rsp_t got;
        mcu_bus_pkg::ahb_rsp_t want;
        logic                  dp_valid;
        int                    stalls;
        string                 what;
        ap       = '0;
        ap.trans = mcu_bus_pkg::trans_idle;
        dp       = '0;
        dp_valid = 1'b0;
        stalls   = 0;
        while (xfer_q.size() > 0 || ap.trans == mcu_bus_pkg::trans_nonseq || dp_valid) begin
            @(negedge HCLK);
            got = rsp;   // rsp moves on clock edges only
            if (dp_valid) begin
                want = expect_rsp(dp, stalls, switches, buttons);
                what = $sformatf("addr %h", dp.addr.raw);
            end else begin
                want       = '0;
                want.ready = 1'b1;
                want.resp  = mcu_bus_pkg::resp_okay;
                what       = "idle bus";
            end
            check_rsp(got, want, dp_valid && !dp.write && want.ready, what);
            check_leds(leds, model_leds);
            @(posedge HCLK);
            if (got.ready) begin
                if (dp_valid && dp.write) model_write(dp);
                dp_valid = (ap.trans == mcu_bus_pkg::trans_nonseq);
                dp       = ap;
                stalls   = 0;
                if (xfer_q.size() > 0) begin
                    ap = xfer_q.pop_front();
                end else begin
                    ap       = '0;
                    ap.trans = mcu_bus_pkg::trans_idle;
                end
            end else begin
                stalls++;   // address phase held
            end
            #1;
            req       = ap;
            req.wdata = dp_valid ? dp.wdata : '0;
        end
        check_leds(leds, model_leds);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        arst_n     = 1'b0;
        req        = '0;
        req.trans  = mcu_bus_pkg::trans_idle;
        switches   = '0;
        buttons    = '0;
        model_leds = '0;
        repeat (5) @(posedge HCLK);
        #1 arst_n = 1'b1;

        // word traffic to both RAMs
        for (int i = 0; i < 48; i++) begin
            r = rnd();
            if (i >= 24 && r[0]) begin
                queue_xfer(pick_known(), 1'b0, size_word, '0);
            end else begin
                a = ram_word_addr(r[31], r);
                queue_xfer(a, 1'b1, size_word, rnd());
                known_words.push_back(a);
            end
        end
        run_queue();

        // byte and halfword lanes
        for (int k = 0; k < 6; k++) begin
            a = ram_word_addr(k[0], rnd());
            queue_xfer(a, 1'b1, size_word, rnd());
            for (int lane = 0; lane < 4; lane++) begin
                queue_xfer({a[31:2], 2'(lane)}, 1'b1, mcu_bus_pkg::size_byte, rnd());
                queue_xfer(a, 1'b0, size_word, '0);   // other lanes must hold
            end
            queue_xfer(a, 1'b1, mcu_bus_pkg::size_half, rnd());
            queue_xfer(a, 1'b0, size_word, '0);
            queue_xfer({a[31:2], 2'b10}, 1'b1, mcu_bus_pkg::size_half, rnd());
            queue_xfer(a, 1'b0, size_word, '0);
            known_words.push_back(a);
        end
        run_queue();

        // GPIO with inputs held long enough for the synchronizers
        for (int k = 0; k < 4; k++) begin
            queue_xfer(gpio_addr(2'd0), 1'b1, size_word, rnd());
            queue_xfer(gpio_addr(2'd0), 1'b0, size_word, '0);
            run_queue();
            r        = rnd();
            switches = r[15:0];
            buttons  = r[19:16];
            add_idle_cycles(3);
            queue_xfer(gpio_addr(2'd1), 1'b0, size_word, '0);
            queue_xfer(gpio_addr(2'd2), 1'b0, size_word, '0);
            queue_xfer(gpio_addr(2'd1), 1'b1, size_word, rnd());
            queue_xfer(gpio_addr(2'd2), 1'b1, size_word, rnd());
            queue_xfer(gpio_addr(2'd1), 1'b0, size_word, '0);
            queue_xfer(gpio_addr(2'd2), 1'b0, size_word, '0);
            queue_xfer(gpio_addr(2'd0), 1'b0, size_word, '0);
            run_queue();
        end

        // unmapped addresses each followed by a normal read
        for (int k = 0; k < 8; k++) begin
            queue_xfer(unmapped_addr(), k[0], size_word, rnd());
            queue_xfer(pick_known(), 1'b0, size_word, '0);
        end
        run_queue();

        // back to back across all slaves
        for (int k = 0; k < 40; k++) begin
            r = rnd();
            a = pick_known();
            case (r[2:0])
                3'd0, 3'd1: queue_xfer(a, 1'b0, size_word, '0);
                3'd2: begin
                    a = ram_word_addr(r[31], rnd());
                    queue_xfer(a, 1'b1, size_word, rnd());
                    known_words.push_back(a);
                end
                3'd3: queue_xfer(gpio_addr(2'd0), 1'b1, size_word, rnd());
                3'd4: queue_xfer(gpio_addr(r[9:8] == 2'd3 ? 2'd0 : r[9:8]), 1'b0, size_word, '0);
                3'd5: queue_xfer(unmapped_addr(), r[3], size_word, rnd());
                3'd6: queue_xfer({a[31:2], r[5:4]}, 1'b1, mcu_bus_pkg::size_byte, rnd());
                default: queue_xfer({a[31:2], r[5], 1'b0}, 1'b1, mcu_bus_pkg::size_half, rnd());
            endcase
        end
        run_queue();

        if (n_checks > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "no bus response was checked");
        end
    end

endmodule

/* hdl/ahb_matrix.sv */
`timescale 1ns/100ps

module ahb_matrix (
    input  logic                               HCLK,
    input  logic                               arst_n,
    input  mcu_bus_pkg::ahb_req_t              req,
    output mcu_bus_pkg::ahb_rsp_t              rsp,
    input  logic [mcu_bus_pkg::n_switches-1:0] switches,
    input  logic [mcu_bus_pkg::n_buttons-1:0]  buttons,
    output logic [mcu_bus_pkg::n_leds-1:0]     leds
);

    logic [mcu_bus_pkg::n_slaves-1:0] sel;
    mcu_bus_pkg::ahb_rsp_t            slave_rsp [mcu_bus_pkg::n_slaves];

    ahb_addr_decoder i_ahb_addr_decoder (
        .addr (req.addr),
        .sel  (sel)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // slaves, all see the muxed ready as hready_in
    ahb_ram_slave #(
        .ADDR_WIDTH  (10),
        .WAIT_STATES (0)
    ) boot_ram (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .hsel      (sel[mcu_bus_pkg::sel_boot_ram]),
        .hready_in (rsp.ready),
        .req       (req),
        .rsp       (slave_rsp[mcu_bus_pkg::sel_boot_ram])
    );

    ahb_ram_slave #(
        .ADDR_WIDTH  (12),
        .WAIT_STATES (1)
    ) main_ram (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .hsel      (sel[mcu_bus_pkg::sel_main_ram]),
        .hready_in (rsp.ready),
        .req       (req),
        .rsp       (slave_rsp[mcu_bus_pkg::sel_main_ram])
    );

    ahb_gpio_slave i_ahb_gpio_slave (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .hsel      (sel[mcu_bus_pkg::sel_gpio]),
        .hready_in (rsp.ready),
        .req       (req),
        .rsp       (slave_rsp[mcu_bus_pkg::sel_gpio]),
        .switches  (switches),
        .buttons   (buttons),
        .leds      (leds)
    );

    ahb_default_slave i_ahb_default_slave (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .hsel      (sel[mcu_bus_pkg::sel_default]),
        .hready_in (rsp.ready),
        .req       (req),
        .rsp       (slave_rsp[mcu_bus_pkg::sel_default])
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // data phase return path
    ahb_response_mux i_ahb_response_mux (
        .HCLK      (HCLK),
        .arst_n    (arst_n),
        .sel       (sel),
        .slave_rsp (slave_rsp),
        .rsp       (rsp)
    );

endmodule

/* hdl/ahb_default_slave.sv */
`timescale 1ns/100ps

module ahb_default_slave (
    input  logic                  HCLK,
    input  logic                  arst_n,
    input  logic                  hsel,
    input  logic                  hready_in,
    input  mcu_bus_pkg::ahb_req_t req,
    output mcu_bus_pkg::ahb_rsp_t rsp
);

    // bit 0 first error cycle, bit 1 second error cycle
    logic [1:0] err_q;

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            err_q <= '0;
        end else begin
            // hready_in is low during the first cycle, so no new transfer lands there
            err_q[0] <= hsel && hready_in && req.trans[1];
            err_q[1] <= err_q[0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // response
    always_comb begin
        rsp.rdata = '0;
        rsp.ready = !err_q[0];
        if (|err_q) begin
            rsp.resp = mcu_bus_pkg::resp_error;
        end else begin
            rsp.resp = mcu_bus_pkg::resp_okay;   // idle transfers
        end
    end

endmodule

/* hdl/ahb_gpio_slave.sv */
`timescale 1ns/100ps

module ahb_gpio_slave (
    input  logic                               HCLK,
    input  logic                               arst_n,
    input  logic                               hsel,
    input  logic                               hready_in,
    input  mcu_bus_pkg::ahb_req_t              req,
    output mcu_bus_pkg::ahb_rsp_t              rsp,
    input  logic [mcu_bus_pkg::n_switches-1:0] switches,
    input  logic [mcu_bus_pkg::n_buttons-1:0]  buttons,
    output logic [mcu_bus_pkg::n_leds-1:0]     leds
);

    logic [mcu_bus_pkg::n_switches-1:0] switches_meta;
    logic [mcu_bus_pkg::n_switches-1:0] switches_sync;
    logic [mcu_bus_pkg::n_buttons-1:0]  buttons_meta;
    logic [mcu_bus_pkg::n_buttons-1:0]  buttons_sync;

    logic       dp_active;
    logic       dp_write;
    logic [1:0] dp_reg;   // word index, 0 leds / 1 switches / 2 buttons

    // ~~~~~~~~~~~~~~~~~~~~
    // input synchronizers
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            switches_meta <= '0;
            switches_sync <= '0;
            buttons_meta  <= '0;
            buttons_sync  <= '0;
        end else begin
            switches_meta <= switches;
            switches_sync <= switches_meta;
            buttons_meta  <= buttons;
            buttons_sync  <= buttons_meta;
        end
    end

    // address phase
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            dp_active <= 1'b0;
        end else if (hready_in) begin
            dp_active <= hsel && req.trans[1];
        end
    end

    always_ff @(posedge HCLK) begin
        if (hsel && hready_in && req.trans[1]) begin
            dp_write <= req.write;
            dp_reg   <= req.addr.map.offset[3:2];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // data phase, only the led register takes writes
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (dp_active && dp_write && dp_reg == 2'd0) begin
            leds <= req.wdata[mcu_bus_pkg::n_leds-1:0];
        end
    end

    always_comb begin
        rsp.rdata = '0;
        rsp.ready = 1'b1;
        rsp.resp  = mcu_bus_pkg::resp_okay;
        case (dp_reg)
            2'd0:    rsp.rdata[mcu_bus_pkg::n_leds-1:0]     = leds;
            2'd1:    rsp.rdata[mcu_bus_pkg::n_switches-1:0] = switches_sync;
            2'd2:    rsp.rdata[mcu_bus_pkg::n_buttons-1:0]  = buttons_sync;
            default: rsp.rdata = '0;
        endcase
    end

endmodule

/* hdl/ahb_ram_slave.sv */
`timescale 1ns/100ps

module ahb_ram_slave #(
    parameter int ADDR_WIDTH  = 10,   // word address bits
    parameter int WAIT_STATES = 0     // extra cycles on reads
) (
    input  logic                  HCLK,
    input  logic                  arst_n,
    input  logic                  hsel,
    input  logic                  hready_in,
    input  mcu_bus_pkg::ahb_req_t req,
    output mcu_bus_pkg::ahb_rsp_t rsp
);

    logic [mcu_bus_pkg::hdata_w-1:0] mem [2**ADDR_WIDTH];

    logic                               accept;
    logic [mcu_bus_pkg::n_lanes-1:0]    ap_strb;
    logic                               dp_active;
    logic                               dp_write;
    logic [ADDR_WIDTH-1:0]              dp_addr;
    logic [mcu_bus_pkg::n_lanes-1:0]    dp_strb;
    logic [mcu_bus_pkg::wait_cnt_w-1:0] wait_cnt;

    assign accept = hsel && hready_in && req.trans[1];  // SEQ counts as NONSEQ

    // ~~~~~~~~~~~~~~~~~~~~
    // byte lanes from size and low offset bits, little endian
    always_comb begin
        case (req.size)
            mcu_bus_pkg::size_byte: ap_strb = 4'b0001 << req.addr.map.offset[1:0];
            mcu_bus_pkg::size_half: ap_strb = req.addr.map.offset[1] ? 4'b1100 : 4'b0011;
            default:                ap_strb = 4'b1111;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // address phase
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            dp_active <= 1'b0;
            wait_cnt  <= '0;
        end else if (hready_in) begin
            dp_active <= accept;
            wait_cnt  <= '0;
        end else if (dp_active) begin
            wait_cnt  <= wait_cnt + 1'b1;  // stalled read
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_write <= req.write;
            dp_addr  <= req.addr.map.offset[ADDR_WIDTH+1:2];
            dp_strb  <= ap_strb;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // data phase
    // writes never stall, so the data phase always ends on this edge
    always_ff @(posedge HCLK) begin
        if (dp_active && dp_write) begin
            for (int i = 0; i < mcu_bus_pkg::n_lanes; i++) begin
                if (dp_strb[i]) begin
                    mem[dp_addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // async read sees a write that finished on the previous edge
    always_comb begin
        rsp.rdata = mem[dp_addr];
        rsp.resp  = mcu_bus_pkg::resp_okay;
        rsp.ready = !(dp_active && !dp_write
                      && wait_cnt != mcu_bus_pkg::wait_cnt_w'(WAIT_STATES));
    end

endmodule

/* hdl/ahb_response_mux.sv */
`timescale 1ns/100ps

module ahb_response_mux (
    input  logic                              HCLK,
    input  logic                              arst_n,
    input  logic [mcu_bus_pkg::n_slaves-1:0] sel,
    input  mcu_bus_pkg::ahb_rsp_t             slave_rsp [mcu_bus_pkg::n_slaves],
    output mcu_bus_pkg::ahb_rsp_t             rsp
);

    logic [mcu_bus_pkg::n_slaves-1:0] sel_dp;  // owner of the current data phase

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            sel_dp <= '0;
        end else if (rsp.ready) begin
            sel_dp <= sel;
        end
    end

    always_comb begin
        // empty select, nothing pending
        rsp.rdata = '0;
        rsp.ready = 1'b1;
        rsp.resp  = mcu_bus_pkg::resp_okay;
        for (int i = 0; i < mcu_bus_pkg::n_slaves; i++) begin
            if (sel_dp[i]) begin
                rsp = slave_rsp[i];
            end
        end
    end

    // AHB two-cycle error, the first error cycle must not end the transfer
    a_two_cycle_error: assert property (
        @(posedge HCLK) disable iff (!arst_n)
        (rsp.resp == mcu_bus_pkg::resp_error && !rsp.ready)
            |=> (rsp.resp == mcu_bus_pkg::resp_error && rsp.ready)
    ) else $error("ERROR response not completed in two cycles");

endmodule

/* hdl/ahb_addr_decoder.sv */
`timescale 1ns/100ps

module ahb_addr_decoder (
    input  mcu_bus_pkg::ahb_addr_u            addr,
    output logic [mcu_bus_pkg::n_slaves-1:0] sel
);

    always_comb begin
        sel = '0;
        case (addr.map.seg)
            mcu_bus_pkg::seg_boot_ram: sel[mcu_bus_pkg::sel_boot_ram] = 1'b1;
            mcu_bus_pkg::seg_main_ram: sel[mcu_bus_pkg::sel_main_ram] = 1'b1;
            mcu_bus_pkg::seg_gpio:     sel[mcu_bus_pkg::sel_gpio]     = 1'b1;
            default:                   sel[mcu_bus_pkg::sel_default]  = 1'b1;  // unmapped
        endcase
    end

endmodule

/* hdl/mcu_bus_pkg.sv */
package mcu_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus widths
    localparam int haddr_w  = 32;
    localparam int hdata_w  = 32;
    localparam int n_lanes  = hdata_w / 8;
    localparam int seg_w    = 10;
    localparam int offset_w = haddr_w - seg_w;     // 22 bit offset inside a segment

    // memory map, segment is addr[31:22]
    localparam logic [seg_w-1:0] seg_main_ram = 10'h000;  // 0x0000_0000
    localparam logic [seg_w-1:0] seg_boot_ram = 10'h07F;  // 0x1FC0_0000
    localparam logic [seg_w-1:0] seg_gpio     = 10'h07E;  // 0x1F80_0000

    // one-hot select bit positions
    localparam int n_slaves     = 4;
    localparam int sel_boot_ram = 0;
    localparam int sel_main_ram = 1;
    localparam int sel_gpio     = 2;
    localparam int sel_default  = 3;

    localparam int n_leds     = 16;
    localparam int n_switches = 16;
    localparam int n_buttons  = 4;

    localparam int wait_cnt_w = 4;   // enough for any sane WAIT_STATES

    // ~~~~~~~~~~~~~~~~~~~~
    // transfer codes, SEQ and BUSY fold into NONSEQ and IDLE
    localparam logic [1:0] trans_idle   = 2'b00;
    localparam logic [1:0] trans_nonseq = 2'b10;

    localparam logic [2:0] size_byte = 3'b000;
    localparam logic [2:0] size_half = 3'b001;

    localparam logic resp_okay  = 1'b0;
    localparam logic resp_error = 1'b1;

    typedef struct packed {
        logic [seg_w-1:0]    seg;
        logic [offset_w-1:0] offset;
    } ahb_map_t;

    // same address word, seen flat or as segment/offset
    typedef union packed {
        logic [haddr_w-1:0] raw;
        ahb_map_t           map;
    } ahb_addr_u;

    typedef struct packed {
        ahb_addr_u          addr;
        logic [1:0]         trans;
        logic               write;
        logic [2:0]         size;
        logic [hdata_w-1:0] wdata;   // data phase only
    } ahb_req_t;

    typedef struct packed {
        logic [hdata_w-1:0] rdata;
        logic               ready;
        logic               resp;
    } ahb_rsp_t;

endpackage
